/* logic/fetch_pkg.sv */
//**************************************************************************
// fetch_pkg: word type, opcode fields, NOP word, execute/memory/fetch
// structs, interrupt entry sequence and the memory reset rule
//**************************************************************************
package fetch_pkg;

	typedef logic [31:0] word_t;

	// opcode lives in the top five bits
	localparam logic [4:0] op_nop  = 5'b01111;
	localparam logic [4:0] op_st   = 5'b10001;
	localparam logic [4:0] op_movi = 5'b00101;
	localparam logic [4:0] op_jr   = 5'b11000;

	localparam word_t nop_instr = {op_nop, 27'd0};

	// resolved branch/jump from execute
	typedef struct packed {
		logic  branch;
		logic  jump;
		logic  [1:0] cond;
		word_t target;
		logic  n;
		logic  z;
	} ex_result_t;

	// one word access, addr is a byte address
	typedef struct packed {
		logic  write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		word_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
		logic  valid;
	} fetch_out_t;

	// entry sequence: save link, load vector base, jump through it
	localparam int INJ_LEN = 3;
	localparam word_t inj_seq [INJ_LEN] = '{
		{op_st,   27'h00_0f00},
		{op_movi, 27'h01_0100},
		{op_jr,   27'h00_0001}
	};

	// reset image: tag byte over the word index
	function automatic word_t mem_reset_word(input logic [31:0] idx);
		return {8'h5A, idx[23:0]};
	endfunction

endpackage

/* logic/fetch_stage.sv */
//**************************************************************************
// fetch_stage: PC register with branch/jump correction, debug and
// interrupt instruction select, flush NOP and the fetch memory client
//**************************************************************************
`timescale 1ns/1ns

module fetch_stage #(
	parameter fetch_pkg::word_t RESET_PC = 32'h0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fetch_pkg::ex_result_t  ex_result,
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   use_dbg,
	input  fetch_pkg::word_t       dbg_instr,
	input  logic                   use_int,
	input  fetch_pkg::word_t       int_instr,
	input  logic                   restore,
	input  fetch_pkg::word_t       saved_pc,
	output fetch_pkg::word_t       current_pc,
	output fetch_pkg::fetch_out_t  fetch,
	output logic                   mem_req,
	output fetch_pkg::mem_req_t    mem_cmd,
	input  logic                   mem_ack,
	input  fetch_pkg::mem_rsp_t    mem_rsp
);

	fetch_pkg::word_t pc;
	fetch_pkg::word_t pc_next;
	fetch_pkg::word_t out_pc;
	fetch_pkg::word_t out_instr;
	logic out_valid;
	logic taken;
	logic hold;
	logic accept;
	logic start;
	logic drop;

	// condition rules, N/Z from the execute flags
	always_comb begin
		taken = 1'b0;
		if (ex_result.jump) begin
			taken = (ex_result.cond != 2'd3);
		end else if (ex_result.branch) begin
			case (ex_result.cond)
				2'd0: taken = ex_result.z;
				2'd1: taken = ~ex_result.z;
				2'd2: taken = ex_result.n;
				default: taken = ~ex_result.n;
			endcase
		end
	end

	// flush overrides stall, injections always hold
	assign hold = (stall & ~flush) | use_dbg | use_int;

	always_comb begin
		if (restore)
			pc_next = saved_pc;
		else if (hold)
			pc_next = pc;
		else if (taken)
			pc_next = ex_result.target;
		else
			pc_next = pc + 32'd4;
	end

	// word is kept only if nothing redirected or held since the request
	assign accept = mem_req & mem_ack & ~drop & ~hold & ~flush & ~restore & ~taken;
	// new request only from a settled PC with the link idle
	assign start = ~mem_req & ~mem_ack & ~hold & ~flush & ~restore & ~taken;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
			mem_req <= 1'b0;
			drop <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (restore | taken | accept)
				pc <= pc_next;
			if (start)
				mem_req <= 1'b1;
			else if (mem_ack)
				mem_req <= 1'b0;
			// remember a redirect seen mid-flight
			if (start)
				drop <= 1'b0;
			else if (mem_req & (flush | restore | taken))
				drop <= 1'b1;
			out_valid <= use_dbg | use_int | accept;
		end
	end

	// request and output payload
	always_ff @(posedge clk) begin
		if (start)
			mem_cmd <= '{write: 1'b0, addr: pc, wdata: '0};
		out_pc <= (use_dbg | use_int) ? pc : mem_cmd.addr;
		if (flush)
			out_instr <= fetch_pkg::nop_instr;
		else if (use_dbg)
			out_instr <= dbg_instr;
		else if (use_int)
			out_instr <= int_instr;
		else
			out_instr <= mem_rsp.rdata;
	end

	assign current_pc = pc;
	assign fetch = '{pc: out_pc, instr: out_instr, valid: out_valid};

	// request held steady until the slave answers
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(mem_req) && mem_req |-> $stable(mem_cmd));

	// debug port and interrupt injector never both inject
	assert property (@(posedge clk) disable iff (!rst_n) !(use_dbg && use_int));

endmodule

/* logic/int_injector.sv */
//**************************************************************************
// int_injector: interrupt entry FSM, saves the PC, feeds the entry
// sequence one word per cycle and pulses restore with irq_ack
//**************************************************************************
`timescale 1ns/1ns

module int_injector (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             irq,
	input  logic             stall,
	input  fetch_pkg::word_t current_pc,
	output logic             use_int,
	output fetch_pkg::word_t int_instr,
	output logic             restore,
	output fetch_pkg::word_t saved_pc,
	output logic             irq_ack
);

	localparam int IW = $clog2(fetch_pkg::INJ_LEN + 1);

	typedef enum logic [1:0] {
		s_idle,
		s_capture,
		s_emit,
		s_restore
	} state_t;

	state_t state;
	logic [IW-1:0] idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			idx <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (irq)
						state <= s_capture;
				end
				s_capture: begin
					idx <= '0;
					state <= s_emit;
				end
				s_emit: begin
					// stall freezes the sequence in place
					if (!stall) begin
						if (idx == IW'(fetch_pkg::INJ_LEN - 1))
							state <= s_restore;
						else
							idx <= idx + 1'b1;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// keep tracking until the first word goes out, a fetch may land late
	always_ff @(posedge clk) begin
		if (state == s_capture || (state == s_emit && idx == '0))
			saved_pc <= current_pc;
	end

	assign use_int = (state == s_emit) & ~stall;
	assign int_instr = fetch_pkg::inj_seq[idx];
	assign restore = (state == s_restore);
	assign irq_ack = restore;

	// single restore cycle, never overlapping an injected word
	assert property (@(posedge clk) disable iff (!rst_n)
		restore |-> !use_int ##1 (!restore && !use_int));

endmodule

/* logic/data_port.sv */
//**************************************************************************
// data_port: load/store client, one command becomes one memory
// handshake, load data held until the command handshake closes
//**************************************************************************
`timescale 1ns/1ns

module data_port (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cmd_req,
	input  fetch_pkg::mem_req_t  cmd,
	output logic                 cmd_ack,
	output fetch_pkg::word_t     cmd_rdata,
	output logic                 mem_req,
	output fetch_pkg::mem_req_t  mem_cmd,
	input  logic                 mem_ack,
	input  fetch_pkg::mem_rsp_t  mem_rsp
);

	logic start;
	logic done;

	// wait for both links to return to idle before taking a command
	assign start = cmd_req & ~cmd_ack & ~mem_req & ~mem_ack;
	assign done = mem_req & mem_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_req <= 1'b0;
			cmd_ack <= 1'b0;
		end else begin
			if (start)
				mem_req <= 1'b1;
			else if (done)
				mem_req <= 1'b0;
			if (done)
				cmd_ack <= 1'b1;
			else if (!cmd_req)
				cmd_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			mem_cmd <= cmd;
		if (done)
			cmd_rdata <= mem_rsp.rdata;
	end

endmodule

/* logic/mem_arbiter.sv */
//**************************************************************************
// mem_arbiter: two clients onto one slave, round-robin on contention,
// grant held for the whole four-phase handshake, registered both ways
//**************************************************************************
`timescale 1ns/1ns

module mem_arbiter (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [1:0]                 req,
	input  fetch_pkg::mem_req_t [1:0]  cmd,
	output logic [1:0]                 ack,
	output fetch_pkg::mem_rsp_t [1:0]  rsp,
	output logic                       mem_req,
	output fetch_pkg::mem_req_t        mem_cmd,
	input  logic                       mem_ack,
	input  fetch_pkg::mem_rsp_t        mem_rsp
);

	logic busy;
	logic sel;
	logic last_win;
	logic pick;
	logic grant;

	// loser of the last contest wins a tie
	assign pick = (req == 2'b11) ? ~last_win : req[1];
	assign grant = ~busy & (|req) & ~mem_req & ~mem_ack;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			sel <= 1'b0;
			last_win <= 1'b1;
			mem_req <= 1'b0;
			ack <= 2'b00;
		end else if (!busy) begin
			ack <= 2'b00;
			if (grant) begin
				busy <= 1'b1;
				sel <= pick;
				last_win <= pick;
				mem_req <= 1'b1;
			end
		end else begin
			// follow the granted client one cycle late
			mem_req <= req[sel];
			ack <= mem_ack ? (2'b01 << sel) : 2'b00;
			// release once every phase is back low
			if (!req[sel] && !mem_req && !mem_ack)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (grant)
			mem_cmd <= cmd[pick];
		if (busy && mem_ack)
			rsp[sel] <= mem_rsp;
	end

	// one client answered at a time
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ack));

endmodule

/* logic/shared_mem.sv */
//**************************************************************************
// shared_mem: word array with reset image, fixed access latency and a
// four-phase req/ack slave port
//**************************************************************************
`timescale 1ns/1ns

module shared_mem #(
	parameter int MEM_WORDS   = 64,
	parameter int MEM_LATENCY = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  fetch_pkg::mem_req_t  cmd,
	output logic                 ack,
	output fetch_pkg::mem_rsp_t  rsp
);

	localparam int CW = $clog2(MEM_LATENCY + 1);

	fetch_pkg::word_t mem [0:MEM_WORDS-1];
	logic [CW-1:0] cnt;
	logic [31:0] word_idx;
	logic fire;

	// byte address to word, wrapping at the array size
	assign word_idx = (cmd.addr >> 2) % MEM_WORDS;
	// last wait cycle, ack goes up on this edge
	assign fire = req & ~ack & (cnt == CW'(MEM_LATENCY - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack <= 1'b0;
			cnt <= '0;
			for (int i = 0; i < MEM_WORDS; i++)
				mem[i] <= fetch_pkg::mem_reset_word(i);
		end else if (ack) begin
			if (!req) begin
				ack <= 1'b0;
				cnt <= '0;
			end
		end else if (fire) begin
			ack <= 1'b1;
			if (cmd.write)
				mem[word_idx] <= cmd.wdata;
		end else if (req) begin
			cnt <= cnt + 1'b1;
		end
	end

	// stores echo their data back
	always_ff @(posedge clk) begin
		if (fire)
			rsp.rdata <= cmd.write ? cmd.wdata : mem[word_idx];
	end

	// ack only answers a request held for the full latency
	assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> req && $past(req, MEM_LATENCY));

endmodule

/* logic/fetch_core.sv */
//**************************************************************************
// fetch_core: fetch stage, interrupt injector and data port sharing one
// word memory through the arbiter
//**************************************************************************
`timescale 1ns/1ns

module fetch_core #(
	parameter int               MEM_WORDS   = 64,
	parameter int               MEM_LATENCY = 2,
	parameter fetch_pkg::word_t RESET_PC    = 32'h0
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  fetch_pkg::ex_result_t  ex_result,
	input  logic                   stall,
	input  logic                   flush,
	input  logic                   use_dbg,
	input  fetch_pkg::word_t       dbg_instr,
	input  logic                   irq,
	output logic                   irq_ack,
	output fetch_pkg::fetch_out_t  fetch,
	input  logic                   cmd_req,
	input  fetch_pkg::mem_req_t    cmd,
	output logic                   cmd_ack,
	output fetch_pkg::word_t       cmd_rdata
);

	// injector to fetch
	fetch_pkg::word_t current_pc;
	fetch_pkg::word_t int_instr;
	fetch_pkg::word_t saved_pc;
	logic use_int;
	logic restore;

	// client 0 is fetch, client 1 the data port
	logic f_req;
	logic d_req;
	fetch_pkg::mem_req_t f_cmd;
	fetch_pkg::mem_req_t d_cmd;
	logic [1:0] arb_ack;
	fetch_pkg::mem_rsp_t [1:0] arb_rsp;

	// arbiter to memory
	logic m_req;
	logic m_ack;
	fetch_pkg::mem_req_t m_cmd;
	fetch_pkg::mem_rsp_t m_rsp;

	fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
		.clk(clk), .rst_n(rst_n),
		.ex_result(ex_result), .stall(stall), .flush(flush),
		.use_dbg(use_dbg), .dbg_instr(dbg_instr),
		.use_int(use_int), .int_instr(int_instr),
		.restore(restore), .saved_pc(saved_pc),
		.current_pc(current_pc), .fetch(fetch),
		.mem_req(f_req), .mem_cmd(f_cmd),
		.mem_ack(arb_ack[0]), .mem_rsp(arb_rsp[0])
	);

	int_injector u_inj (
		.clk(clk), .rst_n(rst_n), .irq(irq), .stall(stall),
		.current_pc(current_pc),
		.use_int(use_int), .int_instr(int_instr),
		.restore(restore), .saved_pc(saved_pc), .irq_ack(irq_ack)
	);

	data_port u_dport (
		.clk(clk), .rst_n(rst_n),
		.cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack), .cmd_rdata(cmd_rdata),
		.mem_req(d_req), .mem_cmd(d_cmd),
		.mem_ack(arb_ack[1]), .mem_rsp(arb_rsp[1])
	);

	mem_arbiter u_arb (
		.clk(clk), .rst_n(rst_n),
		.req({d_req, f_req}), .cmd({d_cmd, f_cmd}),
		.ack(arb_ack), .rsp(arb_rsp),
		.mem_req(m_req), .mem_cmd(m_cmd), .mem_ack(m_ack), .mem_rsp(m_rsp)
	);

	shared_mem #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(MEM_LATENCY)) u_mem (
		.clk(clk), .rst_n(rst_n),
		.req(m_req), .cmd(m_cmd), .ack(m_ack), .rsp(m_rsp)
	);

endmodule

/* test/tb_fetch_core.sv */
//**************************************************************************
// testbench for fetch_core with clock, reset and stimulus, a reference
// model of PC and memory, concurrent checks on fetch and per-test reporting
//**************************************************************************
`timescale 1ns/1ns

module tb_fetch_core;

	localparam int MEM_WORDS = 64;
	localparam logic [31:0] RESET_PC = 32'h0;
	localparam logic [31:0] NOP_WORD = {5'b01111, 27'd0};

	logic clk, rst_n, stall, flush, use_dbg, irq, cmd_req;
	logic [31:0] dbg_instr;
	fetch_pkg::ex_result_t ex_result;
	fetch_pkg::mem_req_t cmd;
	logic irq_ack, cmd_ack;
	logic [31:0] cmd_rdata;
	fetch_pkg::fetch_out_t fetch;

	// reference model state
	logic [31:0] mirror [0:MEM_WORDS-1];
	logic [31:0] exp_pc, dbg_val_q, exp_mem_word, exp_int_word;
	logic dbg_q, int_q, flush_q;
	int int_cnt;
	int errors = 0, tests = 0, failing = 0;

	fetch_core #(.MEM_WORDS(MEM_WORDS), .MEM_LATENCY(2), .RESET_PC(RESET_PC)) UUT (
		.clk(clk), .rst_n(rst_n), .ex_result(ex_result), .stall(stall), .flush(flush),
		.use_dbg(use_dbg), .dbg_instr(dbg_instr), .irq(irq), .irq_ack(irq_ack),
		.fetch(fetch), .cmd_req(cmd_req), .cmd(cmd), .cmd_ack(cmd_ack),
		.cmd_rdata(cmd_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// taken rule for branches and jumps
	function automatic logic redirect_taken(input fetch_pkg::ex_result_t r);
		// jumps fall through only on cond 3
		if (r.jump)
			return r.cond != 2'd3;
		if (!r.branch)
			return 1'b0;
		case (r.cond)
			2'd0: return r.z;
			2'd1: return !r.z;
			2'd2: return r.n;
			default: return !r.n;
		endcase
	endfunction

	// expected words from the model PC and entry count
	always_comb begin
		exp_mem_word = mirror[(exp_pc >> 2) % MEM_WORDS];
		exp_int_word = fetch_pkg::inj_seq[int_cnt % fetch_pkg::INJ_LEN];
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_pc <= RESET_PC;
			dbg_q <= 1'b0;
			int_q <= 1'b0;
			flush_q <= 1'b0;
			int_cnt <= 0;
		end else begin
			dbg_q <= use_dbg;
			dbg_val_q <= dbg_instr;
			int_q <= UUT.use_int;
			flush_q <= flush;
			if (fetch.valid && int_q)
				int_cnt <= int_cnt + 1;
			if (irq_ack)
				int_cnt <= 0;
			// memory word consumed so step one word
			if (fetch.valid && !dbg_q && !int_q)
				exp_pc <= exp_pc + 32'd4;
			// redirect wins over a word finishing on the same edge
			if (redirect_taken(ex_result) && !(stall && !flush) && !use_dbg && !UUT.use_int)
				exp_pc <= ex_result.target;
		end
	end

	a_pc: assert property (@(posedge clk) disable iff (!rst_n) fetch.valid |-> fetch.pc == exp_pc)
		else begin
			errors++;
			$display("MISMATCH fetch.pc got %h exp %h", $sampled(fetch.pc), $sampled(exp_pc));
		end
	a_mem: assert property (@(posedge clk) disable iff (!rst_n)
		fetch.valid && !dbg_q && !int_q |-> fetch.instr == exp_mem_word)
		else begin
			errors++;
			$display("MISMATCH fetch.instr got %h exp %h",
				$sampled(fetch.instr), $sampled(exp_mem_word));
		end
	a_dbg: assert property (@(posedge clk) disable iff (!rst_n)
		fetch.valid && dbg_q |-> fetch.instr == dbg_val_q)
		else begin
			errors++;
			$display("MISMATCH fetch.instr got %h exp %h",
				$sampled(fetch.instr), $sampled(dbg_val_q));
		end
	a_int: assert property (@(posedge clk) disable iff (!rst_n)
		fetch.valid && int_q |-> fetch.instr == exp_int_word)
		else begin
			errors++;
			$display("MISMATCH fetch.instr got %h exp %h",
				$sampled(fetch.instr), $sampled(exp_int_word));
		end
	a_nop: assert property (@(posedge clk) disable iff (!rst_n) flush_q |-> fetch.instr == NOP_WORD)
		else begin
			errors++;
			$display("MISMATCH fetch.instr got %h exp %h", $sampled(fetch.instr), NOP_WORD);
		end

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$finish;
	endtask

	// count memory fetches with optional random stall cycles
	task automatic wait_fetches(input int n, input bit rnd_stall);
		int got;
		int t;
		got = 0;
		t = 0;
		while (got < n) begin
			@(posedge clk);
			stall <= rnd_stall ? ($urandom % 4 == 0) : 1'b0;
			if (fetch.valid && !dbg_q && !int_q) begin
				got++;
				t = 0;
			end else if (++t > 200) begin
				give_up("a memory fetch");
			end
		end
		stall <= 1'b0;
	endtask

	// one four-phase command on the data port
	task automatic run_cmd(input logic wr, input int idx, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int t;
		t = 0;
		@(posedge clk);
		cmd_req <= 1'b1;
		cmd <= '{write: wr, addr: idx * 4, wdata: wdata};
		do begin
			@(posedge clk);
			if (++t > 200)
				give_up("cmd_ack high");
		end while (!cmd_ack);
		rdata = cmd_rdata;
		cmd_req <= 1'b0;
		t = 0;
		do begin
			@(posedge clk);
			if (++t > 200)
				give_up("cmd_ack low");
		end while (cmd_ack);
		if (wr)
			mirror[idx] = wdata;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors > err_before)
			failing++;
		$display("test %s: %0d errors", name, errors - err_before);
	endtask

	initial begin
		int e, idx, t, seen, acks;
		logic [31:0] data, rd;
		fetch_pkg::ex_result_t r;
		void'($urandom(32'hbd86ce6f));
		for (int i = 0; i < MEM_WORDS; i++)
			mirror[i] = {8'h5A, i[23:0]};
		rst_n = 1'b0;
		{stall, flush, use_dbg, irq, cmd_req} = '0;
		dbg_instr = '0;
		ex_result = '0;
		cmd = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		e = errors;
		wait_fetches(24, 1'b1);
		end_test("sequential fetch", e);

		e = errors;
		for (int k = 0; k < 32; k++) begin
			wait_fetches(1, 1'b0);
			r = '{branch: !k[4], jump: k[4], cond: k[3:2], target: ($urandom % 64) * 4,
				n: k[1], z: k[0]};
			ex_result <= r;
			flush <= 1'b1;
			@(posedge clk);
			ex_result <= '0;
			flush <= 1'b0;
			wait_fetches(1, 1'b0);
		end
		end_test("branch and jump redirect", e);

		e = errors;
		repeat (4) begin
			wait_fetches(1, 1'b0);
			use_dbg <= 1'b1;
			dbg_instr <= $urandom;
			@(posedge clk);
			use_dbg <= 1'b0;
			wait_fetches(2, 1'b0);
		end
		end_test("debug injection", e);

		e = errors;
		wait_fetches(1, 1'b0);
		irq <= 1'b1;
		@(posedge clk);
		irq <= 1'b0;
		seen = 0;
		acks = 0;
		t = 0;
		// random stalls while the entry words go out
		while (acks == 0) begin
			@(posedge clk);
			stall <= ($urandom % 3 == 0);
			if (fetch.valid && int_q)
				seen++;
			if (irq_ack)
				acks++;
			if (++t > 200)
				give_up("irq_ack");
		end
		stall <= 1'b0;
		repeat (10) begin
			@(posedge clk);
			if (irq_ack)
				acks++;
		end
		assert (seen == fetch_pkg::INJ_LEN) else begin
			errors++;
			$display("MISMATCH injected count got %h exp %h", seen, fetch_pkg::INJ_LEN);
		end
		assert (acks == 1) else begin
			errors++;
			$display("MISMATCH irq_ack pulses got %h exp %h", acks, 1);
		end
		wait_fetches(3, 1'b0);
		end_test("interrupt entry and return", e);

		e = errors;
		stall <= 1'b1;
		repeat (8) begin
			idx = $urandom % MEM_WORDS;
			data = $urandom;
			run_cmd(1'b1, idx, data, rd);
			run_cmd(1'b0, idx, 32'h0, rd);
			assert (rd == data) else begin
				errors++;
				$display("MISMATCH cmd_rdata got %h exp %h", rd, data);
			end
		end
		stall <= 1'b0;
		// stores land ahead of the fetch stream so later fetches read them back
		repeat (4) begin
			idx = ((exp_pc >> 2) + 10) % MEM_WORDS;
			data = $urandom;
			run_cmd(1'b1, idx, data, rd);
			run_cmd(1'b0, idx, 32'h0, rd);
			assert (rd == data) else begin
				errors++;
				$display("MISMATCH cmd_rdata got %h exp %h", rd, data);
			end
			wait_fetches(14, 1'b0);
		end
		end_test("shared memory through data port", e);

		$display("tests run %0d, failing %0d, errors %0d", tests, failing, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* fetch_core.f */
logic/fetch_pkg.sv
logic/fetch_stage.sv
logic/int_injector.sv
logic/data_port.sv
logic/mem_arbiter.sv
logic/shared_mem.sv
logic/fetch_core.sv
test/tb_fetch_core.sv
